// File: four_stage_processor.f
+incdir+src
src/proc_pkg.sv
src/decode_if.sv
src/program_counter.sv
src/instruction_decoder.sv
src/register_file.sv
src/alu.sv
src/pipeline_control.sv
src/four_stage_processor.sv
sim/proc_clock_gen.sv
sim/proc_tb.sv

// File: sim/proc_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "proc_cfg.svh"

module proc_tb;
  import proc_pkg::*;

  // Program lengths in words, final loop included
  localparam int alu_len   = 59;
  localparam int part_len  = 26;
  localparam int dep_len   = 11;
  localparam int br_len    = 14;
  localparam int nic_len   = 10;
  localparam int cycle_limit = (alu_len + part_len + dep_len + br_len + nic_len) * 4 + 200;

  logic        clk;
  logic        reset;
  logic [31:0] inst_in;
  logic [31:0] pc_out;
  logic [63:0] d_in;
  logic [63:0] d_out;
  logic [31:0] addr_out;
  logic        mem_en;
  logic        mem_wr_en;
  logic [63:0] nic_d_in;
  logic [63:0] nic_d_out;
  logic [1:0]  addr_nic;
  logic        nic_en;
  logic        nic_wr_en;

  logic [31:0] imem [0:63];
  logic [63:0] dmem [0:255];
  logic [63:0] nic_regs [0:3];
  logic        seen_pc [0:63];
  inst_word_u  prog [$];
  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          cycles;

  proc_clock_gen clk_gen (.clk(clk));

  four_stage_processor uut (
    .clk       (clk),
    .reset     (reset),
    .inst_in   (inst_in),
    .pc_out    (pc_out),
    .d_in      (d_in),
    .d_out     (d_out),
    .addr_out  (addr_out),
    .mem_en    (mem_en),
    .mem_wr_en (mem_wr_en),
    .nic_d_in  (nic_d_in),
    .nic_d_out (nic_d_out),
    .addr_nic  (addr_nic),
    .nic_en    (nic_en),
    .nic_wr_en (nic_wr_en)
  );

  assign inst_in = imem[pc_out[7:2]]; // Asynchronous instruction fetch

  // Data memory and NIC answer one cycle after the strobe
  always @(posedge clk) begin
    if (mem_en) begin
      if (mem_wr_en)
        dmem[addr_out[7:0]] <= d_out;
      d_in <= dmem[addr_out[7:0]];
    end
    if (nic_en) begin
      if (nic_wr_en)
        nic_regs[addr_nic] <= nic_d_out;
      nic_d_in <= nic_regs[addr_nic];
    end
  end

  always @(negedge clk) begin
    if (!reset)
      seen_pc[pc_out[7:2]] <= 1'b1;
    if (mem_en && nic_en) begin
      $display("memory and NIC strobes both high at %0t", $time);
      errors++;
    end
    if (mem_en && addr_out[15:14] == `NIC_SEL) begin
      $display("data memory strobed for a NIC address at %0t", $time);
      errors++;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timed out after %0d cycles, a program never reached its final loop", cycles);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic rand_word(output logic [63:0] v);
    v = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_state = lfsr_next(lfsr_state); // One step per bit
      v[i] = lfsr_state[0];
    end
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [63:0] ref_alu(input logic [5:0] fn, input logic [1:0] ww,
                                          input logic [63:0] a, input logic [63:0] b);
    int          w;
    logic [63:0] lm;
    logic [63:0] r;
    logic [63:0] la;
    logic [63:0] lb;
    w  = 8 << ww;
    lm = (w == 64) ? '1 : (64'd1 << w) - 1;
    r  = '0;
    case (fn)
      `FN_AND: r = a & b;
      `FN_OR:  r = a | b;
      `FN_XOR: r = a ^ b;
      `FN_NOT: r = ~a;
      `FN_MOV: r = a;
      `FN_ADD, `FN_SUB: begin
        for (int l = 0; l < 64 / w; l++) begin
          la = (a >> (l * w)) & lm;
          lb = (b >> (l * w)) & lm;
          la = (fn == `FN_ADD) ? la + lb : la - lb;
          r  = r | ((la & lm) << (l * w)); // Wrap inside the lane
        end
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  // Byte j counts from the least significant byte
  function automatic logic [63:0] ref_merge(input logic [63:0] old_v, input logic [63:0] new_v,
                                            input logic [2:0] ppp);
    logic [7:0]  m;
    logic [63:0] r;
    case (ppp)
      3'd1:    m = 8'hF0;
      3'd2:    m = 8'h0F;
      3'd3:    m = 8'hAA;
      3'd4:    m = 8'h55;
      default: m = 8'hFF;
    endcase
    for (int j = 0; j < 8; j++)
      r[8*j +: 8] = m[j] ? new_v[8*j +: 8] : old_v[8*j +: 8];
    return r;
  endfunction

  function automatic logic [5:0] fn_code(input int k);
    case (k)
      0: return `FN_ADD;
      1: return `FN_SUB;
      2: return `FN_AND;
      3: return `FN_OR;
      4: return `FN_XOR;
      5: return `FN_NOT;
      default: return `FN_MOV;
    endcase
  endfunction

  function automatic inst_word_u alu_op(input logic [5:0] fn, input int rd, input int ra,
                                        input int rb, input logic [2:0] ppp,
                                        input logic [1:0] ww);
    inst_word_u w;
    w.r_fields.opcode = `OP_ALU;
    w.r_fields.rd     = rd[4:0];
    w.r_fields.ra     = ra[4:0];
    w.r_fields.rb     = rb[4:0];
    w.r_fields.ppp    = ppp;
    w.r_fields.ww     = ww;
    w.r_fields.func   = fn;
    return w;
  endfunction

  function automatic inst_word_u mem_op(input logic [5:0] op, input int rd,
                                        input logic [15:0] imm);
    inst_word_u w;
    w.m_fields.opcode = op;
    w.m_fields.rd     = rd[4:0];
    w.m_fields.ra     = '0;
    w.m_fields.imm    = imm;
    return w;
  endfunction

  task automatic reset_dut();
    @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);
    for (int i = 1; i < 10; i++) begin
      @(negedge clk);
      foreach (seen_pc[k])
        seen_pc[k] = 1'b0;
      check("pc_out in reset", pc_out, 0);
      check("strobes in reset", {mem_en, mem_wr_en, nic_en, nic_wr_en}, 0);
      @(posedge clk);
    end
    reset <= 1'b0;
    @(negedge clk);
    check("pc_out after reset", pc_out, 0);
    check("strobes after reset", {mem_en, mem_wr_en, nic_en, nic_wr_en}, 0);
  endtask

  // Runs prog from address 0 until its last word, a branch to itself
  task automatic run_program();
    logic [31:0] loop_pc;
    loop_pc = 4 * (prog.size() - 1);
    for (int i = 0; i < 64; i++)
      imem[i] = (i < prog.size()) ? prog[i] : {`OP_NOP, 26'd0};
    reset_dut();
    while (pc_out != loop_pc)
      @(negedge clk);
    repeat (6) @(negedge clk); // Drain the stores behind the loop
  endtask

  task automatic fill_dmem();
    for (int i = 0; i < 256; i++)
      dmem[i] = {32'hDEAD_0000 ^ 32'(i), ~32'(i)};
  endtask

  task automatic test_alu();
    logic [63:0] a;
    logic [63:0] b;
    rand_word(a);
    rand_word(b);
    fill_dmem();
    dmem[0] = a;
    dmem[1] = b;
    prog = {};
    prog.push_back(mem_op(`OP_LD, 1, 16'd0));
    prog.push_back(mem_op(`OP_LD, 2, 16'd1));
    for (int w = 0; w < 4; w++) begin
      for (int k = 0; k < 7; k++) begin
        prog.push_back(alu_op(fn_code(k), 3, 1, 2, 3'd0, w[1:0]));
        prog.push_back(mem_op(`OP_SD, 3, 16'(16 + 7 * w + k)));
      end
    end
    prog.push_back(mem_op(`OP_BEZ, 0, 16'(4 * alu_len - 4)));
    run_program();
    for (int w = 0; w < 4; w++)
      for (int k = 0; k < 7; k++)
        check($sformatf("alu result fn %0d ww %0d", k, w), dmem[16 + 7 * w + k],
              ref_alu(fn_code(k), w[1:0], a, b));
  endtask

  task automatic test_partial();
    logic [63:0] old_v;
    logic [63:0] new_v;
    rand_word(old_v);
    rand_word(new_v);
    fill_dmem();
    dmem[0] = old_v;
    dmem[1] = new_v;
    prog = {};
    prog.push_back(mem_op(`OP_LD, 5, 16'd1));
    for (int p = 0; p < 8; p++) begin
      prog.push_back(mem_op(`OP_LD, 4, 16'd0)); // Restore the known value
      prog.push_back(alu_op(`FN_MOV, 4, 5, 0, p[2:0], 2'd3));
      prog.push_back(mem_op(`OP_SD, 4, 16'(32 + p)));
    end
    prog.push_back(mem_op(`OP_BEZ, 0, 16'(4 * part_len - 4)));
    run_program();
    for (int p = 0; p < 8; p++)
      check($sformatf("partial write ppp %0d", p), dmem[32 + p], ref_merge(old_v, new_v, p[2:0]));
  endtask

  task automatic test_depend();
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] r3;
    logic [63:0] r4;
    rand_word(x);
    rand_word(y);
    fill_dmem();
    dmem[0] = x;
    dmem[1] = y;
    prog = {};
    prog.push_back(mem_op(`OP_LD, 1, 16'd0));
    prog.push_back(mem_op(`OP_LD, 2, 16'd1));
    prog.push_back(alu_op(`FN_ADD, 3, 1, 2, 3'd0, 2'd3));
    prog.push_back(alu_op(`FN_SUB, 4, 3, 1, 3'd0, 2'd3));
    prog.push_back(alu_op(`FN_XOR, 5, 4, 3, 3'd0, 2'd3));
    prog.push_back(mem_op(`OP_SD, 5, 16'd40));
    prog.push_back(mem_op(`OP_LD, 6, 16'd0));
    prog.push_back(alu_op(`FN_ADD, 7, 6, 6, 3'd0, 2'd3)); // Load-use
    prog.push_back(mem_op(`OP_SD, 7, 16'd41));
    prog.push_back(mem_op(`OP_SD, 4, 16'd42));
    prog.push_back(mem_op(`OP_BEZ, 0, 16'(4 * dep_len - 4)));
    run_program();
    r3 = x + y;
    r4 = r3 - x;
    check("dependent xor", dmem[40], r4 ^ r3);
    check("load-use add", dmem[41], x + x);
    check("dependent sub", dmem[42], r4);
  endtask

  task automatic test_branch();
    logic [63:0] v;
    rand_word(v);
    v[0] = 1'b1; // Nonzero
    fill_dmem();
    dmem[0] = '0;
    dmem[1] = v;
    prog = {};
    prog.push_back(mem_op(`OP_LD, 1, 16'd0));
    prog.push_back(mem_op(`OP_LD, 2, 16'd1));
    prog.push_back(mem_op(`OP_BEZ, 1, 16'd20));  // Taken to word 5
    prog.push_back(mem_op(`OP_SD, 2, 16'd50));
    prog.push_back(mem_op(`OP_SD, 2, 16'd51));
    prog.push_back(mem_op(`OP_LD, 3, 16'd1));
    prog.push_back(mem_op(`OP_BNEZ, 3, 16'd36)); // Just loaded, taken to word 9
    prog.push_back(mem_op(`OP_SD, 2, 16'd52));
    prog.push_back(mem_op(`OP_SD, 2, 16'd53));
    prog.push_back(mem_op(`OP_BEZ, 3, 16'd48));  // Not taken
    prog.push_back(mem_op(`OP_BNEZ, 1, 16'd52)); // Not taken
    prog.push_back(mem_op(`OP_SD, 2, 16'd54));
    prog.push_back(mem_op(`OP_SD, 3, 16'd55));
    prog.push_back(mem_op(`OP_BEZ, 0, 16'(4 * br_len - 4)));
    run_program();
    for (int i = 50; i < 54; i++)
      check($sformatf("skipped store %0d", i), dmem[i], {32'hDEAD_0000 ^ 32'(i), ~32'(i)});
    check("fall-through store r2", dmem[54], v);
    check("fall-through store r3", dmem[55], v);
    check("bez target fetched", seen_pc[5], 1);
    check("bnez target fetched", seen_pc[9], 1);
    check("word after squash fetched", {seen_pc[4], seen_pc[8]}, 0);
  endtask

  task automatic test_nic();
    logic [63:0] p;
    logic [63:0] q;
    logic [63:0] n3;
    rand_word(p);
    rand_word(q);
    rand_word(n3);
    fill_dmem();
    dmem[0] = p;
    dmem[1] = q;
    nic_regs[0] = '0;
    nic_regs[1] = '0;
    nic_regs[2] = '0;
    nic_regs[3] = n3;
    prog = {};
    prog.push_back(mem_op(`OP_LD, 1, 16'd0));
    prog.push_back(mem_op(`OP_LD, 2, 16'd1));
    prog.push_back(mem_op(`OP_SD, 1, 16'hC001));
    prog.push_back(mem_op(`OP_SD, 2, 16'hC002));
    prog.push_back(mem_op(`OP_LD, 3, 16'hC003));
    prog.push_back(mem_op(`OP_SD, 3, 16'd60));
    prog.push_back(mem_op(`OP_LD, 4, 16'hC001));
    prog.push_back(alu_op(`FN_ADD, 5, 4, 3, 3'd0, 2'd3));
    prog.push_back(mem_op(`OP_SD, 5, 16'd61));
    prog.push_back(mem_op(`OP_BEZ, 0, 16'(4 * nic_len - 4)));
    run_program();
    check("nic_regs[1]", nic_regs[1], p);
    check("nic_regs[2]", nic_regs[2], q);
    check("nic load stored", dmem[60], n3);
    check("nic load sum", dmem[61], p + n3);
  endtask

  initial begin
    reset      = 1'b1;
    d_in       = '0;
    nic_d_in   = '0;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    lfsr_state = 32'd96;
    test_alu();
    test_partial();
    test_depend();
    test_branch();
    test_nic();
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/proc_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module proc_clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk; // 40 ns period

endmodule

`default_nettype wire

// File: src/four_stage_processor.sv
`timescale 1ns/10ps
`default_nettype none
`include "proc_cfg.svh"

module four_stage_processor (
  input  logic               clk,
  input  logic               reset,
  input  logic [0:`INST_W-1] inst_in,
  output logic [0:31]        pc_out,
  input  logic [0:`DATA_W-1] d_in,
  output logic [0:`DATA_W-1] d_out,
  output logic [0:31]        addr_out,
  output logic               mem_en,
  output logic               mem_wr_en,
  input  logic [0:`DATA_W-1] nic_d_in,
  output logic [0:`DATA_W-1] nic_d_out,
  output logic [0:1]         addr_nic,
  output logic               nic_en,
  output logic               nic_wr_en
);
  import proc_pkg::*;

  localparam logic [0:`INST_W-1] nop_word = {`OP_NOP, {(`INST_W-6){1'b0}}};

  // IF/ID
  inst_word_u         id_inst;
  logic [0:`DATA_W-1] rf_a;
  logic [0:`DATA_W-1] rf_b;
  logic               stall;
  logic               branch_taken;
  logic               branch;
  logic               id_uses_ra;
  logic               id_uses_rb;
  logic               id_is_branch;

  // ID/EX
  logic [0:`REG_ADDR_W-1] ex_ra;
  logic [0:`REG_ADDR_W-1] ex_rb;
  logic [0:`REG_ADDR_W-1] ex_rd;
  logic [0:5]             ex_func;
  logic [0:`IMM_W-1]      ex_imm;
  elem_width_e            ex_ww;
  part_sel_e              ex_ppp;
  logic [0:`DATA_W-1]     ex_a_data;
  logic [0:`DATA_W-1]     ex_b_data;
  logic                   ex_is_alu;
  logic                   ex_is_ld;
  logic                   ex_is_sd;
  logic                   ex_writes;
  logic                   ex_nic;
  fwd_sel_e               fwd_a;
  fwd_sel_e               fwd_b;
  logic [0:`DATA_W-1]     a_op;
  logic [0:`DATA_W-1]     b_op;
  logic [0:`DATA_W-1]     alu_result;

  // EX/WB
  logic [0:`REG_ADDR_W-1] wb_rd;
  part_sel_e              wb_ppp;
  logic [0:`DATA_W-1]     wb_alu;
  logic                   wb_is_alu;
  logic                   wb_is_ld;
  logic                   wb_nic;
  logic                   wb_writes;
  logic [0:`DATA_W-1]     wb_value;
  logic [0:`DATA_W/8-1]   wb_mask; // Bytes that the WB write replaces

  decode_if dec_bus ();

  // Bytes outside the mask keep the EX copy of the register
  function automatic logic [0:`DATA_W-1] fwd_merge(input logic [0:`DATA_W-1] old_v,
                                                   input logic [0:`DATA_W-1] new_v,
                                                   input logic [0:`DATA_W/8-1] mask);
    logic [0:`DATA_W-1] r;
    for (int i = 0; i < `DATA_W / 8; i++)
      r[8*i +: 8] = mask[i] ? new_v[8*i +: 8] : old_v[8*i +: 8];
    return r;
  endfunction

  program_counter u_pc (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .branch        (branch),
    .branch_target ({{(32-`IMM_W){1'b0}}, dec_bus.imm}),
    .pc            (pc_out)
  );

  instruction_decoder u_dec (
    .inst (id_inst),
    .dec  (dec_bus)
  );

  register_file u_rf (
    .clk     (clk),
    .reset   (reset),
    .ra_addr (dec_bus.ra),
    .rb_addr (dec_bus.rb),
    .wr_addr (wb_rd),
    .wr_en   (wb_writes),
    .wr_part (wb_ppp),
    .wr_data (wb_value),
    .ra_data (rf_a),
    .rb_data (rf_b)
  );

  pipeline_control u_ctl (
    .id_ra        (dec_bus.ra),
    .id_rb        (dec_bus.rb),
    .id_uses_ra   (id_uses_ra),
    .id_uses_rb   (id_uses_rb),
    .id_is_branch (id_is_branch),
    .ex_rd        (ex_rd),
    .ex_is_ld     (ex_is_ld),
    .ex_writes    (ex_writes),
    .ex_ra        (ex_ra),
    .ex_rb        (ex_rb),
    .wb_rd        (wb_rd),
    .wb_writes    (wb_writes),
    .stall        (stall),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b)
  );

  alu u_alu (
    .func   (ex_func),
    .ww     (ex_ww),
    .a      (a_op),
    .b      (b_op),
    .result (alu_result)
  );

  // ID stage operand use and branch resolution
  assign id_uses_ra   = dec_bus.is_alu;
  assign id_uses_rb   = (dec_bus.is_alu && dec_bus.func != `FN_NOT && dec_bus.func != `FN_MOV) ||
                        dec_bus.is_sd || id_is_branch;
  assign id_is_branch = dec_bus.is_bez || dec_bus.is_bnez;
  assign branch_taken = (dec_bus.is_bez && rf_b == '0) || (dec_bus.is_bnez && rf_b != '0);
  assign branch       = branch_taken && !stall;

  always_ff @(posedge clk) begin
    if (reset)
      id_inst <= nop_word;
    else if (!stall)
      id_inst <= branch ? nop_word : inst_in; // Squash the slot behind a taken branch
  end

  always_ff @(posedge clk) begin
    if (reset || stall) begin
      ex_is_alu <= 1'b0; // Bubble
      ex_is_ld  <= 1'b0;
      ex_is_sd  <= 1'b0;
    end else begin
      ex_is_alu <= dec_bus.is_alu;
      ex_is_ld  <= dec_bus.is_ld;
      ex_is_sd  <= dec_bus.is_sd;
    end
  end

  always_ff @(posedge clk) begin
    ex_ra     <= dec_bus.ra;
    ex_rb     <= dec_bus.rb;
    ex_rd     <= dec_bus.rd;
    ex_func   <= dec_bus.func;
    ex_imm    <= dec_bus.imm;
    ex_ww     <= dec_bus.ww;
    ex_ppp    <= dec_bus.ppp;
    ex_a_data <= rf_a;
    ex_b_data <= rf_b;
  end

  // Forwarded value matches what the register file keeps after a partial write
  always_comb begin
    case (wb_ppp)
      ps_upper: wb_mask = 8'b1111_0000;
      ps_lower: wb_mask = 8'b0000_1111;
      ps_even:  wb_mask = 8'b1010_1010;
      ps_odd:   wb_mask = 8'b0101_0101;
      default:  wb_mask = 8'b1111_1111;
    endcase
  end

  // EX stage operands, memory and NIC drive
  assign a_op      = (fwd_a == fwd_wb) ? fwd_merge(ex_a_data, wb_value, wb_mask) : ex_a_data;
  assign b_op      = (fwd_b == fwd_wb) ? fwd_merge(ex_b_data, wb_value, wb_mask) : ex_b_data;
  assign ex_writes = ex_is_alu || ex_is_ld;
  assign ex_nic    = (ex_imm[0:1] == `NIC_SEL);

  assign addr_out  = {{(32-`IMM_W){1'b0}}, ex_imm};
  assign d_out     = b_op;
  assign mem_en    = (ex_is_ld || ex_is_sd) && !ex_nic;
  assign mem_wr_en = ex_is_sd && !ex_nic;
  assign addr_nic  = ex_imm[14:15];
  assign nic_d_out = b_op;
  assign nic_en    = (ex_is_ld || ex_is_sd) && ex_nic;
  assign nic_wr_en = ex_is_sd && ex_nic;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_is_alu <= 1'b0;
      wb_is_ld  <= 1'b0;
    end else begin
      wb_is_alu <= ex_is_alu;
      wb_is_ld  <= ex_is_ld;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd  <= ex_rd;
    wb_ppp <= ex_ppp;
    wb_alu <= alu_result;
    wb_nic <= ex_nic;
  end

  // Load data arrives from memory or NIC during WB
  assign wb_writes = wb_is_alu || wb_is_ld;
  assign wb_value  = !wb_is_ld ? wb_alu : (wb_nic ? nic_d_in : d_in);

endmodule

`default_nettype wire

// File: src/pipeline_control.sv
`timescale 1ns/10ps
`default_nettype none
`include "proc_cfg.svh"

module pipeline_control (
  input  logic                   [0:`REG_ADDR_W-1] id_ra,
  input  logic                   [0:`REG_ADDR_W-1] id_rb,
  input  logic                   id_uses_ra,
  input  logic                   id_uses_rb,
  input  logic                   id_is_branch,
  input  logic                   [0:`REG_ADDR_W-1] ex_rd,
  input  logic                   ex_is_ld,
  input  logic                   ex_writes,
  input  logic                   [0:`REG_ADDR_W-1] ex_ra,
  input  logic                   [0:`REG_ADDR_W-1] ex_rb,
  input  logic                   [0:`REG_ADDR_W-1] wb_rd,
  input  logic                   wb_writes,
  output logic                   stall,
  output proc_pkg::fwd_sel_e     fwd_a,
  output proc_pkg::fwd_sel_e     fwd_b
);
  import proc_pkg::*;

  logic ex_live;   // EX writes a real register
  logic wb_live;
  logic load_use;
  logic branch_dep;

  assign ex_live = ex_writes && (ex_rd != '0);
  assign wb_live = wb_writes && (wb_rd != '0);

  // Load data shows up only in WB, one cycle late for the next instruction
  assign load_use = ex_live && ex_is_ld &&
                    ((id_uses_ra && id_ra == ex_rd) || (id_uses_rb && id_rb == ex_rd));

  // Branch tests in ID and has no path from EX
  assign branch_dep = ex_live && id_is_branch && (id_rb == ex_rd);

  assign stall = load_use || branch_dep;

  assign fwd_a = (wb_live && wb_rd == ex_ra) ? fwd_wb : fwd_reg;
  assign fwd_b = (wb_live && wb_rd == ex_rb) ? fwd_wb : fwd_reg;

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "proc_cfg.svh"

module alu (
  input  logic [0:5]            func,
  input  proc_pkg::elem_width_e ww,
  input  logic [0:`DATA_W-1]    a,
  input  logic [0:`DATA_W-1]    b,
  output logic [0:`DATA_W-1]    result
);
  import proc_pkg::*;

  localparam int nbytes = `DATA_W / 8;

  logic [2:0]         lane_mask; // Lane size in bytes minus one
  logic               is_sub;
  logic [0:`DATA_W-1] sum;

  always_comb begin
    case (ww)
      ew_byte: lane_mask = 3'd0;
      ew_half: lane_mask = 3'd1;
      ew_word: lane_mask = 3'd3;
      default: lane_mask = 3'd7;
    endcase
  end

  assign is_sub = (func == `FN_SUB);

  // Byte-wide ripple from the LSB byte, carry restarts at each lane
  always_comb begin
    logic       carry;
    logic [8:0] part;
    logic [7:0] a_byte;
    logic [7:0] b_byte;
    carry = is_sub;
    for (int k = 0; k < nbytes; k++) begin
      a_byte = a[`DATA_W - 8*(k+1) +: 8];
      b_byte = b[`DATA_W - 8*(k+1) +: 8] ^ {8{is_sub}}; // Two's complement for SUB
      if ((3'(k) & lane_mask) == 3'd0)
        carry = is_sub;
      part = {1'b0, a_byte} + {1'b0, b_byte} + {8'b0, carry};
      sum[`DATA_W - 8*(k+1) +: 8] = part[7:0];
      carry = part[8];
    end
  end

  always_comb begin
    case (func)
      `FN_AND: result = a & b;
      `FN_OR:  result = a | b;
      `FN_XOR: result = a ^ b;
      `FN_NOT: result = ~a;
      `FN_MOV: result = a;
      `FN_ADD,
      `FN_SUB: result = sum;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "proc_cfg.svh"

module register_file (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [0:`REG_ADDR_W-1] ra_addr,
  input  logic [0:`REG_ADDR_W-1] rb_addr,
  input  logic [0:`REG_ADDR_W-1] wr_addr,
  input  logic                   wr_en,
  input  proc_pkg::part_sel_e    wr_part,
  input  logic [0:`DATA_W-1]     wr_data,
  output logic [0:`DATA_W-1]     ra_data,
  output logic [0:`DATA_W-1]     rb_data
);
  import proc_pkg::*;

  localparam int nregs  = 1 << `REG_ADDR_W;
  localparam int nbytes = `DATA_W / 8;

  logic [0:`DATA_W-1] regs [1:nregs-1]; // r0 is not stored
  logic [0:nbytes-1]  byte_mask;
  logic [0:`DATA_W-1] old_value;
  logic [0:`DATA_W-1] merged;
  logic               wr_live;

  function automatic logic [0:`DATA_W-1] read_port(input logic [0:`REG_ADDR_W-1] addr);
    if (addr == '0)
      return '0;
    if (wr_live && addr == wr_addr)
      return merged; // Write-through from WB
    return regs[addr];
  endfunction

  always_comb begin
    case (wr_part)
      ps_upper: byte_mask = 8'b1111_0000;
      ps_lower: byte_mask = 8'b0000_1111;
      ps_even:  byte_mask = 8'b1010_1010;
      ps_odd:   byte_mask = 8'b0101_0101;
      default:  byte_mask = 8'b1111_1111;
    endcase
  end

  assign wr_live   = wr_en && (wr_addr != '0);
  assign old_value = (wr_addr == '0) ? '0 : regs[wr_addr];

  // Keep unselected bytes of the old value
  always_comb begin
    for (int i = 0; i < nbytes; i++) begin
      merged[8*i +: 8] = byte_mask[i] ? wr_data[8*i +: 8] : old_value[8*i +: 8];
    end
  end

  always_comb begin
    ra_data = read_port(ra_addr);
    rb_data = read_port(rb_addr);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_addr] <= merged;
    end
  end

endmodule

`default_nettype wire

// File: src/instruction_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "proc_cfg.svh"

module instruction_decoder (
  input  proc_pkg::inst_word_u inst,
  decode_if.dec                dec
);
  import proc_pkg::*;

  always_comb begin
    // Memory view by default, one class flag set below
    dec.rd      = inst.m_fields.rd;
    dec.ra      = inst.m_fields.ra;
    dec.rb      = '0;
    dec.func    = '0;
    dec.imm     = inst.m_fields.imm;
    dec.ppp     = ps_all;
    dec.ww      = ew_dword;
    dec.is_alu  = 1'b0;
    dec.is_ld   = 1'b0;
    dec.is_sd   = 1'b0;
    dec.is_bez  = 1'b0;
    dec.is_bnez = 1'b0;
    dec.is_nop  = 1'b0;

    case (inst.r_fields.opcode)
      `OP_ALU: begin
        dec.rd     = inst.r_fields.rd;
        dec.ra     = inst.r_fields.ra;
        dec.rb     = inst.r_fields.rb;
        dec.func   = inst.r_fields.func;
        dec.imm    = '0;
        dec.ppp    = part_sel_e'(inst.r_fields.ppp);
        dec.ww     = elem_width_e'(inst.r_fields.ww);
        dec.is_alu = 1'b1;
      end
      `OP_LD: dec.is_ld = 1'b1;
      `OP_SD: begin
        dec.rb    = inst.m_fields.rd; // Store data read on port b
        dec.is_sd = 1'b1;
      end
      `OP_BEZ: begin
        dec.rb     = inst.m_fields.rd;
        dec.is_bez = 1'b1;
      end
      `OP_BNEZ: begin
        dec.rb      = inst.m_fields.rd;
        dec.is_bnez = 1'b1;
      end
      default: dec.is_nop = 1'b1; // OP_NOP and anything unknown
    endcase
  end

endmodule

`default_nettype wire

// File: src/program_counter.sv
`timescale 1ns/10ps
`default_nettype none

module program_counter (
  input  logic        clk,
  input  logic        reset,
  input  logic        stall,
  input  logic        branch,
  input  logic [0:31] branch_target,
  output logic [0:31] pc
);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (stall) begin
      pc <= pc; // Load-use or branch hazard
    end else if (branch) begin
      pc <= branch_target;
    end else begin
      pc <= pc + 32'd4;
    end
  end

endmodule

`default_nettype wire

// File: src/decode_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "proc_cfg.svh"

interface decode_if;
  import proc_pkg::*;

  logic [0:`REG_ADDR_W-1] ra;
  logic [0:`REG_ADDR_W-1] rb; // Also the stored or tested register
  logic [0:`REG_ADDR_W-1] rd;
  logic [0:5]             func;
  logic [0:`IMM_W-1]      imm;
  part_sel_e              ppp;
  elem_width_e            ww;
  logic                   is_alu;
  logic                   is_ld;
  logic                   is_sd;
  logic                   is_bez;
  logic                   is_bnez;
  logic                   is_nop;

  modport dec (output ra, rb, rd, func, imm, ppp, ww,
               output is_alu, is_ld, is_sd, is_bez, is_bnez, is_nop);

  modport pipe (input ra, rb, rd, func, imm, ppp, ww,
                input is_alu, is_ld, is_sd, is_bez, is_bnez, is_nop);

endinterface

`default_nettype wire

// File: src/proc_pkg.sv
`default_nettype none
`include "proc_cfg.svh"

package proc_pkg;

  // Register format, ALU ops
  typedef struct packed {
    logic [0:5]             opcode;
    logic [0:`REG_ADDR_W-1] rd;
    logic [0:`REG_ADDR_W-1] ra;
    logic [0:`REG_ADDR_W-1] rb;
    logic [0:2]             ppp;
    logic [0:1]             ww;
    logic [0:5]             func;
  } r_fields_t;

  // Memory and branch format
  typedef struct packed {
    logic [0:5]             opcode;
    logic [0:`REG_ADDR_W-1] rd;
    logic [0:`REG_ADDR_W-1] ra;
    logic [0:`IMM_W-1]      imm;
  } m_fields_t;

  typedef union packed {
    r_fields_t r_fields;
    m_fields_t m_fields;
  } inst_word_u;

  typedef enum logic [1:0] {
    ew_byte  = 2'b00,
    ew_half  = 2'b01,
    ew_word  = 2'b10,
    ew_dword = 2'b11
  } elem_width_e;

  // Codes 5 to 7 fall back to a full write
  typedef enum logic [2:0] {
    ps_all   = 3'b000,
    ps_upper = 3'b001, // Bits 0 to 31
    ps_lower = 3'b010, // Bits 32 to 63
    ps_even  = 3'b011,
    ps_odd   = 3'b100
  } part_sel_e;

  typedef enum logic {
    fwd_reg = 1'b0,
    fwd_wb  = 1'b1
  } fwd_sel_e;

endpackage

`default_nettype wire

// File: src/proc_cfg.svh
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Datapath and instruction widths
`define DATA_W     64
`define INST_W     32
`define REG_ADDR_W 5
`define IMM_W      16

// Major opcodes
`define OP_ALU  6'b101010
`define OP_LD   6'b100000
`define OP_SD   6'b100001
`define OP_BEZ  6'b100010
`define OP_BNEZ 6'b100011
`define OP_NOP  6'b111100

// ALU function field, R-format only
`define FN_AND 6'b000001
`define FN_OR  6'b000010
`define FN_XOR 6'b000011
`define FN_NOT 6'b000100
`define FN_MOV 6'b000101
`define FN_ADD 6'b000110
`define FN_SUB 6'b000111

`define NIC_SEL 2'b11 // Top two imm bits that map to the NIC

`endif
